// File: build.f
common/fetch_cache_pkg.sv
common/cpu_ctrl_pkg.sv
hdl/instr_rom.sv
icache/icache.sv
fetch/fetch_unit.sv
hdl/fetch_subsys_top.sv
sim/tb_fetch_subsys.sv

// File: common/cpu_ctrl_pkg.sv
package cpu_ctrl_pkg;

    // Redirect commands from execute
    typedef enum logic [1:0] {
        E2F_CMD_NONE          = 2'd0,
        E2F_CMD_BRANCHTAKEN   = 2'd1,
        E2F_CMD_BUBBLE_BRANCH = 2'd2,
        E2F_CMD_FLUSH         = 2'd3
    } e2f_cmd_t;

    // Execute to fetch
    typedef struct packed {
        logic        ready;
        e2f_cmd_t    cmd;
        logic [31:0] branch_target;
        logic [31:0] bubble_branch_target;
    } e2f_t;

    // Fetch to execute
    typedef struct packed {
        logic [31:0] instr;
        logic [31:0] pc;
        logic        exc_start;
        logic [31:0] cause;
    } f2e_t;

    // Interrupt lines with their enables
    typedef struct packed {
        logic timer;
        logic timer_en;
        logic exti;
        logic exti_en;
    } irq_t;

    // Debug module requests
    typedef struct packed {
        logic        request;
        logic        set_pc;
        logic        exit_request;
        logic [31:0] pc;
    } dbg_req_t;

    // Trap causes, mcause format
    localparam logic [31:0] EXC_INSTR_MISALIGNED   = 32'd0;
    localparam logic [31:0] EXC_INSTR_ACCESS_FAULT = 32'd1;
    localparam logic [31:0] EXC_INSTR_PAGE_FAULT   = 32'd12;
    localparam logic [31:0] EXC_TIMER_IRQ          = 32'h8000_0007;
    localparam logic [31:0] EXC_EXT_IRQ            = 32'h8000_000B;

    // addi x0,x0,0
    localparam logic [31:0] INSTR_NOP = 32'h0000_0013;

    // ROM word = byte address xor salt, low bits forced to 11
    localparam logic [31:0] ROM_SALT = 32'h6A5C_0000;

endpackage

// File: common/fetch_cache_pkg.sv
package fetch_cache_pkg;

    // Commands from the fetch unit to the instruction cache
    typedef enum logic [1:0] {
        CACHE_CMD_NONE      = 2'd0,
        CACHE_CMD_EXECUTE   = 2'd1,
        CACHE_CMD_FLUSH_ALL = 2'd2
    } cache_cmd_t;

    // Cache response codes, one per cycle
    typedef enum logic [2:0] {
        CACHE_RESP_IDLE        = 3'd0,
        CACHE_RESP_WAIT        = 3'd1,
        CACHE_RESP_DONE        = 3'd2,
        CACHE_RESP_ACCESSFAULT = 3'd3,
        CACHE_RESP_MISALIGNED  = 3'd4,
        // Reserved for an MMU, never produced here
        CACHE_RESP_PAGEFAULT   = 3'd5
    } cache_resp_t;

    // Refill request, word address, travels with valid/ready
    typedef struct packed {
        logic [31:0] addr;
    } rom_req_t;

    // Refill data, travels with rsp_valid
    typedef struct packed {
        logic [31:0] data;
    } rom_resp_t;

endpackage

// File: fetch/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit #(
    parameter logic [31:0] RESET_VECTOR = 32'h0000_2000
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic [31:0]                  csr_mtvec,
    input  cpu_ctrl_pkg::irq_t           irq,
    input  cpu_ctrl_pkg::dbg_req_t       dbg,
    input  cpu_ctrl_pkg::e2f_t           e2f,
    input  fetch_cache_pkg::cache_resp_t c_resp,
    input  logic                         c_reset_done,
    input  logic [31:0]                  c_load_data,
    output logic                         dbg_mode,
    output logic                         dbg_done,
    output cpu_ctrl_pkg::f2e_t           f2e,
    output fetch_cache_pkg::cache_cmd_t  c_cmd,
    output logic [31:0]                  c_address
);

    // Fetch state
    logic [31:0] pc;
    logic        bubble;
    logic        flushing;
    logic [31:0] saved_instr;
    logic        exc_start_q;
    logic [31:0] cause_q;

    // Next-state values
    logic [31:0] pc_nxt;
    logic        bubble_nxt;
    logic        flushing_nxt;
    logic        dbg_mode_nxt;
    logic        exc_start_nxt;
    logic [31:0] cause_nxt;

    // Cache response decode
    logic        cache_done;
    logic        cache_idle;
    logic        cache_wait;
    logic        cache_error;
    logic        new_fetch_begin;
    logic [31:0] pc_plus_4;

    assign cache_done  = (c_resp == fetch_cache_pkg::CACHE_RESP_DONE);
    assign cache_idle  = (c_resp == fetch_cache_pkg::CACHE_RESP_IDLE);
    assign cache_wait  = (c_resp == fetch_cache_pkg::CACHE_RESP_WAIT);
    assign cache_error = (c_resp == fetch_cache_pkg::CACHE_RESP_ACCESSFAULT) ||
                         (c_resp == fetch_cache_pkg::CACHE_RESP_MISALIGNED) ||
                         (c_resp == fetch_cache_pkg::CACHE_RESP_PAGEFAULT);

    // Current word consumed or faulted, pick the next PC
    assign new_fetch_begin = e2f.ready && (cache_done || cache_idle || cache_error);
    assign pc_plus_4 = pc + 32'd4;

    // Cache sees the address it will be asked for
    assign c_address = pc_nxt;

    // Output toward execute
    always_comb begin
        f2e.instr     = cpu_ctrl_pkg::INSTR_NOP;
        f2e.pc        = pc;
        f2e.exc_start = exc_start_q;
        f2e.cause     = cause_q;
        if (cache_done && !flushing && !dbg_mode) begin
            f2e.instr = c_load_data;
        end else if (cache_idle && !bubble) begin
            // Replay of the word last shown
            f2e.instr = saved_instr;
        end
    end

    // Next PC, cache command and trap decision
    always_comb begin
        pc_nxt        = pc;
        bubble_nxt    = bubble;
        flushing_nxt  = flushing;
        dbg_mode_nxt  = dbg_mode;
        exc_start_nxt = 1'b0;
        cause_nxt     = '0;
        c_cmd         = fetch_cache_pkg::CACHE_CMD_NONE;
        dbg_done      = 1'b0;
        if (c_reset_done) begin
            if (dbg_mode) begin
                // No fetches while halted
                if (dbg.exit_request && (cache_idle || cache_done)) begin
                    dbg_mode_nxt = 1'b0;
                    bubble_nxt   = 1'b1;
                end else if (dbg.set_pc) begin
                    pc_nxt     = dbg.pc;
                    bubble_nxt = 1'b1;
                    dbg_done   = 1'b1;
                end
            end else if (flushing) begin
                // Keep asking until the walk reports done
                if (cache_done) begin
                    flushing_nxt = 1'b0;
                end else begin
                    c_cmd = fetch_cache_pkg::CACHE_CMD_FLUSH_ALL;
                end
            end else if (bubble && cache_idle && e2f.ready) begin
                // Restart from a redirected PC
                c_cmd      = fetch_cache_pkg::CACHE_CMD_EXECUTE;
                bubble_nxt = 1'b0;
            end else if (new_fetch_begin) begin
                if (dbg.request) begin
                    dbg_mode_nxt = 1'b1;
                    bubble_nxt   = 1'b1;
                    pc_nxt       = cache_error ? pc : pc_plus_4;
                end else if (irq.exti && irq.exti_en) begin
                    bubble_nxt    = 1'b1;
                    pc_nxt        = csr_mtvec;
                    exc_start_nxt = 1'b1;
                    cause_nxt     = cpu_ctrl_pkg::EXC_EXT_IRQ;
                end else if (irq.timer && irq.timer_en) begin
                    bubble_nxt    = 1'b1;
                    pc_nxt        = csr_mtvec;
                    exc_start_nxt = 1'b1;
                    cause_nxt     = cpu_ctrl_pkg::EXC_TIMER_IRQ;
                end else if (e2f.cmd == cpu_ctrl_pkg::E2F_CMD_BUBBLE_BRANCH) begin
                    bubble_nxt = 1'b1;
                    pc_nxt     = e2f.bubble_branch_target;
                end else if (e2f.cmd == cpu_ctrl_pkg::E2F_CMD_FLUSH) begin
                    bubble_nxt   = 1'b1;
                    flushing_nxt = 1'b1;
                    pc_nxt       = pc_plus_4;
                end else if (e2f.cmd == cpu_ctrl_pkg::E2F_CMD_BRANCHTAKEN) begin
                    pc_nxt = e2f.branch_target;
                    c_cmd  = fetch_cache_pkg::CACHE_CMD_EXECUTE;
                end else if (cache_error) begin
                    bubble_nxt    = 1'b1;
                    pc_nxt        = csr_mtvec;
                    exc_start_nxt = 1'b1;
                    if (c_resp == fetch_cache_pkg::CACHE_RESP_MISALIGNED) begin
                        cause_nxt = cpu_ctrl_pkg::EXC_INSTR_MISALIGNED;
                    end else if (c_resp == fetch_cache_pkg::CACHE_RESP_ACCESSFAULT) begin
                        cause_nxt = cpu_ctrl_pkg::EXC_INSTR_ACCESS_FAULT;
                    end else begin
                        cause_nxt = cpu_ctrl_pkg::EXC_INSTR_PAGE_FAULT;
                    end
                end else begin
                    pc_nxt = pc_plus_4;
                    c_cmd  = fetch_cache_pkg::CACHE_CMD_EXECUTE;
                end
            end else if (!bubble && !cache_wait) begin
                // Execute stalled, present the same PC again
                c_cmd = fetch_cache_pkg::CACHE_CMD_EXECUTE;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc          <= RESET_VECTOR;
            bubble      <= 1'b1;
            flushing    <= 1'b0;
            dbg_mode    <= 1'b0;
            exc_start_q <= 1'b0;
            cause_q     <= '0;
        end else begin
            pc          <= pc_nxt;
            bubble      <= bubble_nxt;
            flushing    <= flushing_nxt;
            dbg_mode    <= dbg_mode_nxt;
            exc_start_q <= exc_start_nxt;
            cause_q     <= cause_nxt;
        end
    end

    always_ff @(posedge clk) begin
        saved_instr <= f2e.instr;
    end

    // Cache must finish its clear before any request
    a_no_cmd_before_ready: assert property (@(posedge clk) disable iff (!rst_n)
        !c_reset_done |-> c_cmd == fetch_cache_pkg::CACHE_CMD_NONE);

endmodule

// File: hdl/fetch_subsys_top.sv
`timescale 1ns/1ps

module fetch_subsys_top #(
    parameter logic [31:0] RESET_VECTOR = 32'h0000_2000,
    parameter logic [31:0] ROM_BASE     = 32'h0000_2000,
    parameter int          ROM_WORDS    = 1024,
    parameter int          CACHE_LINES  = 16,
    parameter int          ROM_LATENCY  = 3
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [31:0]            csr_mtvec,
    input  cpu_ctrl_pkg::irq_t     irq,
    input  cpu_ctrl_pkg::dbg_req_t dbg,
    input  cpu_ctrl_pkg::e2f_t     e2f,
    output cpu_ctrl_pkg::f2e_t     f2e,
    output logic                   dbg_mode,
    output logic                   dbg_done
);

    // Fetch to cache
    fetch_cache_pkg::cache_cmd_t  c_cmd;
    logic [31:0]                  c_address;
    fetch_cache_pkg::cache_resp_t c_resp;
    logic [31:0]                  c_load_data;
    logic                         c_reset_done;

    // Cache to ROM
    logic                         rom_req_valid;
    logic                         rom_req_ready;
    fetch_cache_pkg::rom_req_t    rom_req;
    logic                         rom_rsp_valid;
    fetch_cache_pkg::rom_resp_t   rom_rsp;

    fetch_unit #(
        .RESET_VECTOR(RESET_VECTOR)
    ) u_fetch_unit (
        .clk          (clk),
        .rst_n        (rst_n),
        .csr_mtvec    (csr_mtvec),
        .irq          (irq),
        .dbg          (dbg),
        .e2f          (e2f),
        .c_resp       (c_resp),
        .c_reset_done (c_reset_done),
        .c_load_data  (c_load_data),
        .dbg_mode     (dbg_mode),
        .dbg_done     (dbg_done),
        .f2e          (f2e),
        .c_cmd        (c_cmd),
        .c_address    (c_address)
    );

    icache #(
        .ROM_BASE    (ROM_BASE),
        .ROM_WORDS   (ROM_WORDS),
        .CACHE_LINES (CACHE_LINES)
    ) u_icache (
        .clk           (clk),
        .rst_n         (rst_n),
        .cmd           (c_cmd),
        .address       (c_address),
        .resp          (c_resp),
        .load_data     (c_load_data),
        .reset_done    (c_reset_done),
        .rom_req_valid (rom_req_valid),
        .rom_req_ready (rom_req_ready),
        .rom_req       (rom_req),
        .rom_rsp_valid (rom_rsp_valid),
        .rom_rsp       (rom_rsp)
    );

    instr_rom #(
        .ROM_BASE    (ROM_BASE),
        .ROM_LATENCY (ROM_LATENCY)
    ) u_instr_rom (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (rom_req_valid),
        .req_ready (rom_req_ready),
        .req       (rom_req),
        .rsp_valid (rom_rsp_valid),
        .rsp       (rom_rsp)
    );

endmodule

// File: hdl/instr_rom.sv
`timescale 1ns/1ps

module instr_rom #(
    parameter logic [31:0] ROM_BASE    = 32'h0000_2000,
    parameter int          ROM_LATENCY = 3
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       req_valid,
    output logic                       req_ready,
    input  fetch_cache_pkg::rom_req_t  req,
    output logic                       rsp_valid,
    output fetch_cache_pkg::rom_resp_t rsp
);

    localparam int CNT_W = (ROM_LATENCY > 1) ? $clog2(ROM_LATENCY) : 1;

    logic             busy;
    logic [CNT_W-1:0] cnt;
    logic [31:0]      byte_addr;

    // Single outstanding request
    assign req_ready = !busy;
    assign rsp_valid = busy && (cnt == '0);
    assign rsp.data  = (byte_addr ^ cpu_ctrl_pkg::ROM_SALT) | 32'h0000_0003;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy <= 1'b0;
            cnt  <= '0;
        end else if (req_valid && req_ready) begin
            busy <= 1'b1;
            cnt  <= CNT_W'(ROM_LATENCY - 1);
        end else if (busy) begin
            if (cnt == '0) begin
                busy <= 1'b0;
            end else begin
                cnt <= cnt - 1'b1;
            end
        end
    end

    // Word address back to bytes
    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            byte_addr <= {req.addr[29:0], 2'b00};
        end
    end

    // Answer exactly ROM_LATENCY cycles after acceptance
    a_rsp_after_req: assert property (@(posedge clk) disable iff (!rst_n)
        req_valid && req_ready |-> ##ROM_LATENCY rsp_valid);

    // Cache range check keeps requests inside the ROM
    a_req_in_rom: assert property (@(posedge clk) disable iff (!rst_n)
        req_valid && req_ready |-> {req.addr[29:0], 2'b00} >= ROM_BASE);

endmodule

// File: icache/icache.sv
`timescale 1ns/1ps

module icache #(
    parameter logic [31:0] ROM_BASE    = 32'h0000_2000,
    parameter int          ROM_WORDS   = 1024,
    parameter int          CACHE_LINES = 16
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  fetch_cache_pkg::cache_cmd_t  cmd,
    input  logic [31:0]                  address,
    output fetch_cache_pkg::cache_resp_t resp,
    output logic [31:0]                  load_data,
    output logic                         reset_done,
    output logic                         rom_req_valid,
    input  logic                         rom_req_ready,
    output fetch_cache_pkg::rom_req_t    rom_req,
    input  logic                         rom_rsp_valid,
    input  fetch_cache_pkg::rom_resp_t   rom_rsp
);

    localparam int          IDX_W   = $clog2(CACHE_LINES);
    localparam int          TAG_W   = 30 - IDX_W;
    localparam logic [31:0] ROM_END = ROM_BASE + 32'(4 * ROM_WORDS);

    typedef enum logic [1:0] {S_CLEAR, S_IDLE, S_REFILL, S_FLUSH} state_t;

    state_t state;

    // One word per line
    logic [CACHE_LINES-1:0] valid_q;
    logic [TAG_W-1:0]       tag_mem  [CACHE_LINES];
    logic [31:0]            data_mem [CACHE_LINES];

    logic [IDX_W-1:0] walk_idx;
    logic [31:0]      miss_addr;

    // Lookup on the incoming address
    logic [IDX_W-1:0] idx;
    logic [TAG_W-1:0] tag;
    logic             misaligned;
    logic             out_of_range;
    logic             hit;

    // Refill target
    logic [IDX_W-1:0] miss_idx;
    logic [TAG_W-1:0] miss_tag;

    logic walking;
    logic lookup;
    logic fill;

    assign idx          = address[IDX_W+1:2];
    assign tag          = address[31:IDX_W+2];
    assign misaligned   = (address[1:0] != 2'b00);
    assign out_of_range = (address < ROM_BASE) || (address >= ROM_END);
    assign hit          = valid_q[idx] && (tag_mem[idx] == tag);

    assign miss_idx = miss_addr[IDX_W+1:2];
    assign miss_tag = miss_addr[31:IDX_W+2];

    assign walking = (state == S_CLEAR) || (state == S_FLUSH);
    assign lookup  = (state == S_IDLE) && (cmd == fetch_cache_pkg::CACHE_CMD_EXECUTE);
    assign fill    = (state == S_REFILL) && rom_rsp_valid;

    assign reset_done   = (state != S_CLEAR);
    assign rom_req.addr = {2'b00, miss_addr[31:2]};

    // Control FSM
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state         <= S_CLEAR;
            walk_idx      <= '0;
            resp          <= fetch_cache_pkg::CACHE_RESP_WAIT;
            rom_req_valid <= 1'b0;
        end else begin
            if (rom_req_valid && rom_req_ready) begin
                rom_req_valid <= 1'b0;
            end
            case (state)
                S_CLEAR, S_FLUSH: begin
                    // One line per cycle, index wraps back to zero
                    walk_idx <= walk_idx + 1'b1;
                    if (walk_idx == IDX_W'(CACHE_LINES - 1)) begin
                        state <= S_IDLE;
                        resp  <= (state == S_FLUSH) ? fetch_cache_pkg::CACHE_RESP_DONE
                                                    : fetch_cache_pkg::CACHE_RESP_IDLE;
                    end
                end
                S_REFILL: begin
                    if (rom_rsp_valid) begin
                        state <= S_IDLE;
                        resp  <= fetch_cache_pkg::CACHE_RESP_DONE;
                    end
                end
                default: begin
                    resp <= fetch_cache_pkg::CACHE_RESP_IDLE;
                    if (cmd == fetch_cache_pkg::CACHE_CMD_FLUSH_ALL) begin
                        state <= S_FLUSH;
                        resp  <= fetch_cache_pkg::CACHE_RESP_WAIT;
                    end else if (lookup) begin
                        // Faults before the tag compare
                        if (misaligned) begin
                            resp <= fetch_cache_pkg::CACHE_RESP_MISALIGNED;
                        end else if (out_of_range) begin
                            resp <= fetch_cache_pkg::CACHE_RESP_ACCESSFAULT;
                        end else if (hit) begin
                            resp <= fetch_cache_pkg::CACHE_RESP_DONE;
                        end else begin
                            state         <= S_REFILL;
                            resp          <= fetch_cache_pkg::CACHE_RESP_WAIT;
                            rom_req_valid <= 1'b1;
                        end
                    end
                end
            endcase
        end
    end

    // Arrays and data path
    always_ff @(posedge clk) begin
        if (walking) begin
            valid_q[walk_idx] <= 1'b0;
        end
        if (lookup) begin
            miss_addr <= address;
            load_data <= data_mem[idx];
        end
        if (fill) begin
            valid_q[miss_idx]  <= 1'b1;
            tag_mem[miss_idx]  <= miss_tag;
            data_mem[miss_idx] <= rom_rsp.data;
            load_data          <= rom_rsp.data;
        end
    end

    a_req_held: assert property (@(posedge clk) disable iff (!rst_n)
        rom_req_valid && !rom_req_ready |=> rom_req_valid);

    // DONE only after a lookup, a refill or a flush walk
    a_done_has_source: assert property (@(posedge clk) disable iff (!rst_n)
        resp == fetch_cache_pkg::CACHE_RESP_DONE |->
            $past(lookup || state == S_REFILL || state == S_FLUSH));

endmodule

// File: run_sim.sh
#!/bin/sh
# Compile and run the fetch subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_fetch_subsys -f build.f

out=$(./obj_dir/Vtb_fetch_subsys)
echo "$out"

# Exit status follows the testbench verdict
echo "$out" | grep -q "^Simulation finished: PASS$"

// File: sim/tb_fetch_subsys.sv
`timescale 1ns/1ps

module tb_fetch_subsys;

    localparam logic [31:0] RESET_VECTOR = 32'h0000_2000;
    localparam logic [31:0] ROM_BASE     = 32'h0000_2000;
    localparam int          ROM_WORDS    = 1024;
    localparam int          CACHE_LINES  = 16;
    localparam int          ROM_LATENCY  = 3;

    // Redirect targets, all inside the ROM window unless marked
    localparam logic [31:0] MTVEC     = 32'h0000_2C00;
    localparam logic [31:0] BR_TARGET = 32'h0000_2800;
    localparam logic [31:0] BB_TARGET = 32'h0000_2A40;
    localparam logic [31:0] DBG_PC    = 32'h0000_2E00;
    localparam logic [31:0] UNALIGNED = 32'h0000_2802;
    // Below ROM_BASE
    localparam logic [31:0] OUTSIDE   = 32'h0000_1000;

    // Deliveries per test 72 + 48 + 6 + 6 + 4 + 2
    localparam int DELIVERIES = 138;
    localparam int TIMEOUT_NS = DELIVERIES * (ROM_LATENCY + 10) * 8 + 2000;
    // Longest gap between deliveries, reset clear or flush walk included
    localparam int WAIT_LIMIT = 2 * CACHE_LINES + 4 * ROM_LATENCY + 32;

    logic                   clk;
    logic                   rst_n;
    logic [31:0]            csr_mtvec;
    cpu_ctrl_pkg::irq_t     irq;
    cpu_ctrl_pkg::dbg_req_t dbg;
    cpu_ctrl_pkg::e2f_t     e2f;
    cpu_ctrl_pkg::f2e_t     f2e;
    logic                   dbg_mode;
    logic                   dbg_done;

    integer      seed;
    int          errors;
    int          checks;
    // Address of the next expected delivery
    logic [31:0] cur_pc;
    int          last_wait;
    logic        exc_seen;
    logic [31:0] exc_cause;

    // Side inputs applied only in the cycle of the next delivery
    cpu_ctrl_pkg::e2f_cmd_t pend_cmd;
    logic [31:0]            pend_target;
    cpu_ctrl_pkg::irq_t     pend_irq;
    logic                   pend_dbg;

    fetch_subsys_top #(
        .RESET_VECTOR (RESET_VECTOR),
        .ROM_BASE     (ROM_BASE),
        .ROM_WORDS    (ROM_WORDS),
        .CACHE_LINES  (CACHE_LINES),
        .ROM_LATENCY  (ROM_LATENCY)
    ) u_fetch_subsys_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .csr_mtvec (csr_mtvec),
        .irq       (irq),
        .dbg       (dbg),
        .e2f       (e2f),
        .f2e       (f2e),
        .dbg_mode  (dbg_mode),
        .dbg_done  (dbg_done)
    );

    always #4 clk = ~clk;

    // ROM content rule
    function automatic logic [31:0] expected_word(input logic [31:0] addr);
        return (addr ^ cpu_ctrl_pkg::ROM_SALT) | 32'h0000_0003;
    endfunction

    function automatic cpu_ctrl_pkg::irq_t irq_lines(input logic timer, input logic timer_en,
                                                   input logic exti, input logic exti_en);
        cpu_ctrl_pkg::irq_t lines;
        lines.timer    = timer;
        lines.timer_en = timer_en;
        lines.exti     = exti;
        lines.exti_en  = exti_en;
        return lines;
    endfunction

    task automatic check_f2e(input cpu_ctrl_pkg::f2e_t exp, input cpu_ctrl_pkg::f2e_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("mismatch at %0t: f2e expected pc=%h instr=%h exc=%b cause=%h",
                     $time, exp.pc, exp.instr, exp.exc_start, exp.cause);
            $display("    got pc=%h instr=%h exc=%b cause=%h",
                     act.pc, act.instr, act.exc_start, act.cause);
        end
    endtask

    task automatic check_cause(input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("mismatch at %0t: cause expected %h got %h", $time, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("mismatch at %0t: %s expected %b got %b", $time, name, exp, act);
        end
    endtask

    // One falling edge, side inputs back to quiet
    task automatic tick();
        @(negedge clk);
        e2f.cmd     = cpu_ctrl_pkg::E2F_CMD_NONE;
        irq         = '0;
        dbg.request = 1'b0;
        if (f2e.exc_start) begin
            exc_seen  = 1'b1;
            exc_cause = f2e.cause;
        end
    endtask

    // Wait for the next delivery and check it against cur_pc
    task automatic deliver(input logic rand_ready);
        cpu_ctrl_pkg::f2e_t exp;
        logic               got;
        int                 waited;
        got    = 1'b0;
        waited = 0;
        while (!got && waited <= WAIT_LIMIT) begin
            tick();
            e2f.ready = rand_ready ? 1'($random(seed)) : 1'b1;
            if (e2f.ready && f2e.instr != cpu_ctrl_pkg::INSTR_NOP) begin
                got = 1'b1;
                // Execute answers in the delivery cycle
                e2f.cmd                  = pend_cmd;
                e2f.branch_target        = pend_target;
                e2f.bubble_branch_target = pend_target;
                irq                      = pend_irq;
                dbg.request              = pend_dbg;
                exp.instr     = expected_word(cur_pc);
                exp.pc        = cur_pc;
                exp.exc_start = 1'b0;
                exp.cause     = '0;
                check_f2e(exp, f2e);
            end else begin
                waited++;
            end
        end
        if (!got) begin
            errors++;
            $display("no delivery of pc %h within %0d cycles", cur_pc, WAIT_LIMIT);
        end
        last_wait = waited;
        if (pend_cmd == cpu_ctrl_pkg::E2F_CMD_BRANCHTAKEN ||
            pend_cmd == cpu_ctrl_pkg::E2F_CMD_BUBBLE_BRANCH) begin
            cur_pc = pend_target;
        end else begin
            // Flush resumes after the flushed word too
            cur_pc = cur_pc + 32'd4;
        end
        pend_cmd = cpu_ctrl_pkg::E2F_CMD_NONE;
        pend_irq = '0;
        pend_dbg = 1'b0;
    endtask

    // Sequential run, the last delivery carries a redirect
    task automatic run_seq(input int count, input logic rand_ready, input logic expect_hits,
                           input cpu_ctrl_pkg::e2f_cmd_t last_cmd, input logic [31:0] last_target);
        int          i;
        logic [31:0] pc_now;
        for (i = 0; i < count; i++) begin
            if (i == count - 1) begin
                pend_cmd    = last_cmd;
                pend_target = last_target;
            end
            pc_now = cur_pc;
            deliver(rand_ready);
            // A hit follows the previous delivery with no gap
            if (expect_hits && i > 0 && last_wait != 0) begin
                errors++;
                $display("pc %h took %0d extra cycles, not served from the cache",
                         pc_now, last_wait);
            end
        end
    endtask

    // Trap at the next delivery, then fetch from mtvec
    task automatic expect_trap(input cpu_ctrl_pkg::irq_t lines, input cpu_ctrl_pkg::e2f_cmd_t cmd,
                               input logic [31:0] target, input logic [31:0] cause);
        exc_seen    = 1'b0;
        pend_irq    = lines;
        pend_cmd    = cmd;
        pend_target = target;
        deliver(1'b0);
        cur_pc = MTVEC;
        deliver(1'b0);
        check_bit("exc_start", 1'b1, exc_seen);
        check_cause(cause, exc_cause);
    endtask

    task automatic test_sequential();
        run_seq(40, 1'b0, 1'b0, cpu_ctrl_pkg::E2F_CMD_BUBBLE_BRANCH, RESET_VECTOR);
        // Loop of one cache size, filled once then replayed from the cache
        run_seq(CACHE_LINES, 1'b0, 1'b0, cpu_ctrl_pkg::E2F_CMD_BUBBLE_BRANCH, RESET_VECTOR);
        run_seq(CACHE_LINES, 1'b0, 1'b1, cpu_ctrl_pkg::E2F_CMD_NONE, '0);
    endtask

    task automatic test_backpressure();
        run_seq(48, 1'b1, 1'b0, cpu_ctrl_pkg::E2F_CMD_NONE, '0);
    endtask

    task automatic test_redirects();
        run_seq(1, 1'b0, 1'b0, cpu_ctrl_pkg::E2F_CMD_BRANCHTAKEN, BR_TARGET);
        run_seq(2, 1'b0, 1'b0, cpu_ctrl_pkg::E2F_CMD_BUBBLE_BRANCH, BB_TARGET);
        run_seq(2, 1'b0, 1'b0, cpu_ctrl_pkg::E2F_CMD_FLUSH, '0);
        // Refilled from the ROM after the flush walk
        run_seq(1, 1'b0, 1'b0, cpu_ctrl_pkg::E2F_CMD_NONE, '0);
    endtask

    task automatic test_interrupts();
        expect_trap(irq_lines(1'b1, 1'b1, 1'b1, 1'b1), cpu_ctrl_pkg::E2F_CMD_NONE, '0,
                    cpu_ctrl_pkg::EXC_EXT_IRQ);
        expect_trap(irq_lines(1'b1, 1'b1, 1'b1, 1'b0), cpu_ctrl_pkg::E2F_CMD_NONE, '0,
                    cpu_ctrl_pkg::EXC_TIMER_IRQ);
        // Lines high, enables low
        exc_seen = 1'b0;
        pend_irq = irq_lines(1'b1, 1'b0, 1'b1, 1'b0);
        deliver(1'b0);
        deliver(1'b0);
        check_bit("exc_start", 1'b0, exc_seen);
    endtask

    task automatic test_faults();
        expect_trap('0, cpu_ctrl_pkg::E2F_CMD_BRANCHTAKEN, UNALIGNED,
                    cpu_ctrl_pkg::EXC_INSTR_MISALIGNED);
        expect_trap('0, cpu_ctrl_pkg::E2F_CMD_BRANCHTAKEN, OUTSIDE,
                    cpu_ctrl_pkg::EXC_INSTR_ACCESS_FAULT);
    endtask

    task automatic test_debug();
        int i;
        pend_dbg = 1'b1;
        deliver(1'b0);
        tick();
        check_bit("dbg_mode", 1'b1, dbg_mode);
        // Halted, nothing may reach execute
        for (i = 0; i < 12; i++) begin
            tick();
            e2f.ready = 1'b1;
            if (f2e.instr != cpu_ctrl_pkg::INSTR_NOP) begin
                errors++;
                $display("instruction %h shown to execute while in debug mode", f2e.instr);
            end
        end
        tick();
        dbg.set_pc = 1'b1;
        dbg.pc     = DBG_PC;
        #1;
        check_bit("dbg_done", 1'b1, dbg_done);
        tick();
        dbg.set_pc       = 1'b0;
        dbg.exit_request = 1'b1;
        tick();
        dbg.exit_request = 1'b0;
        check_bit("dbg_mode", 1'b0, dbg_mode);
        cur_pc = DBG_PC;
        deliver(1'b0);
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired after %0d ns with tests still running", TIMEOUT_NS);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        seed        = 32'hc4e39ffd;
        clk         = 1'b0;
        rst_n       = 1'b0;
        csr_mtvec   = MTVEC;
        irq         = '0;
        dbg         = '0;
        e2f         = '0;
        e2f.ready   = 1'b1;
        errors      = 0;
        checks      = 0;
        cur_pc      = RESET_VECTOR;
        last_wait   = 0;
        exc_seen    = 1'b0;
        exc_cause   = '0;
        pend_cmd    = cpu_ctrl_pkg::E2F_CMD_NONE;
        pend_target = '0;
        pend_irq    = '0;
        pend_dbg    = 1'b0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        check_bit("dbg_mode", 1'b0, dbg_mode);
        check_bit("dbg_done", 1'b0, dbg_done);
        test_sequential();
        test_backpressure();
        test_redirects();
        test_interrupts();
        test_faults();
        test_debug();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule
